// File: rtl/lsu_defines.svh
// ##########################################################################
// LSU memory endpoint defines
// Flit and header field widths, class code, line length, RAM size
// ##########################################################################

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Flit layout
`define LSU_KIND_W 2         // Flit kind bits on top of the payload
`define LSU_DATA_W 32        // Payload width

// Header fields
`define LSU_NODE_W 5         // Node address
`define LSU_CLASS_W 3        // Packet class
`define LSU_BSEL_W 4         // Byte select
`define LSU_HDR_RSVD_W 11    // Unused low header bits

`define LSU_CLASS_LSU 3'd2   // Load/store class code

// Wishbone cycle type codes
`define LSU_CTI_W 3
`define LSU_CTI_INCR 3'b010  // More beats follow
`define LSU_CTI_END 3'b111   // Last beat

// Memory side
`define LSU_LINE_WORDS 4     // Words per burst read
`define LSU_RAM_AW 8         // Word address bits, wraps at 256 words
`define LSU_NODE_ID_DEFAULT 5'd3

`endif

// File: rtl/lsu_pkg.sv
// ##########################################################################
// LSU memory endpoint types
// Flit, packet header and Wishbone bundles, FSM state encoding
// ##########################################################################

`include "lsu_defines.svh"

package lsu_pkg;

   typedef logic [`LSU_DATA_W-1:0] word_t;
   typedef logic [`LSU_NODE_W-1:0] node_t;
   typedef logic [`LSU_BSEL_W-1:0] bsel_t;

   typedef enum logic [`LSU_KIND_W-1:0] {
      FLIT_MID  = 2'b00,
      FLIT_HEAD = 2'b01,
      FLIT_LAST = 2'b10
   } flit_kind_e;

   typedef struct packed {
      flit_kind_e kind;
      word_t      payload;
   } flit_t;  // 34 bits on the wire

   typedef enum logic [1:0] {
      MSG_READREQ  = 2'd0,
      MSG_WRITEREQ = 2'd1,
      MSG_READRESP = 2'd2
   } msgtype_e;

   // Head flit payload, MSB first
   typedef struct packed {
      node_t                      dest;
      logic [`LSU_CLASS_W-1:0]    cls;
      node_t                      src;
      msgtype_e                   msgtype;
      logic                       rtype;   // Opaque, echoed back
      logic                       burst;   // 0 single, 1 line
      bsel_t                      bsel;
      logic [`LSU_HDR_RSVD_W-1:0] rsvd;
   } lsu_hdr_t;

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      word_t                 adr;
      word_t                 dat;
      bsel_t                 sel;
      logic [`LSU_CTI_W-1:0] cti;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

   typedef enum logic [2:0] {
      ST_IDLE, ST_RD_ADDR, ST_RD_HDR, ST_RD_DATA, ST_WR_ADDR, ST_WR_DATA, ST_DROP
   } ep_state_e;

endpackage

// File: rtl/flit_fifo.sv
// ##########################################################################
// Flit FIFO
// Circular buffer between the endpoint and the NoC output port
// ##########################################################################

module flit_fifo
   import lsu_pkg::*;
#(
   parameter int DEPTH = 2
) (
   input  logic  clk,
   input  logic  rst,
   input  flit_t in_flit_i,
   input  logic  in_valid_i,
   output logic  in_ready_o,
   output flit_t out_flit_o,
   output logic  out_valid_o,
   input  logic  out_ready_i,
   output logic  empty_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);  // Must hold DEPTH itself

   flit_t            slots [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Pointer step with wrap at DEPTH, not at a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready_o  = (count != CNT_W'(DEPTH));  // Space left
   assign out_valid_o = (count != '0);
   assign empty_o     = (count == '0);
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;
   assign out_flit_o  = slots[rd_ptr];             // Head of queue

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         if (push && !pop)      count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) slots[wr_ptr] <= in_flit_i;
   end

   a_count_max: assert property (@(posedge clk) disable iff (rst)
      count <= CNT_W'(DEPTH));

endmodule

// File: rtl/lsu_mem_endpoint.sv
// ##########################################################################
// LSU memory endpoint
// Decodes load/store request packets, runs Wishbone accesses on the RAM
// and builds read response packets into the response FIFO
// ##########################################################################

`include "lsu_defines.svh"

module lsu_mem_endpoint
   import lsu_pkg::*;
#(
   parameter node_t NODE_ID = `LSU_NODE_ID_DEFAULT
) (
   input  logic    clk,
   input  logic    rst,
   input  flit_t   noc_in_i,
   input  logic    noc_in_valid_i,
   output logic    noc_in_ready_o,
   output flit_t   push_flit_o,
   output logic    push_valid_o,
   input  logic    push_ready_i,
   input  logic    fifo_empty_i,
   output wb_req_t wb_req_o,
   input  wb_rsp_t wb_rsp_i
);

   localparam int CNT_W = (`LSU_LINE_WORDS > 1) ? $clog2(`LSU_LINE_WORDS) : 1;

   ep_state_e        state, nxt_state;
   word_t            req_addr, nxt_req_addr;
   node_t            req_src, nxt_req_src;
   logic             req_rtype, nxt_req_rtype;
   logic             req_burst, nxt_req_burst;
   bsel_t            req_bsel, nxt_req_bsel;
   word_t            wr_data, nxt_wr_data;
   logic             wr_busy, nxt_wr_busy;   // Write strobe waiting for ack
   logic [CNT_W-1:0] beat_cnt, nxt_beat_cnt; // Burst word index

   lsu_hdr_t in_hdr;
   lsu_hdr_t rsp_hdr;
   wb_req_t  rd_req;
   wb_req_t  wr_req;
   logic     in_xfer;
   logic     last_beat;

   assign in_hdr    = lsu_hdr_t'(noc_in_i.payload);  // Only meaningful on a head flit
   assign in_xfer   = noc_in_valid_i & noc_in_ready_o;
   assign last_beat = ~req_burst | (beat_cnt == CNT_W'(`LSU_LINE_WORDS - 1));

   // Input ready depends on state only, never on valid
   always_comb begin
      case (state)
         ST_IDLE:    noc_in_ready_o = 1'b1;
         ST_RD_ADDR: noc_in_ready_o = fifo_empty_i;  // Whole response must fit
         ST_WR_ADDR: noc_in_ready_o = 1'b1;
         ST_WR_DATA: noc_in_ready_o = ~wr_busy;
         ST_DROP:    noc_in_ready_o = 1'b1;          // Foreign packets at full rate
         default:    noc_in_ready_o = 1'b0;
      endcase
   end

   // Response header
   always_comb begin
      rsp_hdr         = '0;
      rsp_hdr.dest    = req_src;  // Back to the requester
      rsp_hdr.cls     = `LSU_CLASS_LSU;
      rsp_hdr.src     = NODE_ID;
      rsp_hdr.msgtype = MSG_READRESP;
      rsp_hdr.rtype   = req_rtype;
      rsp_hdr.burst   = req_burst;
   end

   // Read beat, full word
   always_comb begin
      rd_req     = '0;
      rd_req.cyc = 1'b1;
      rd_req.stb = 1'b1;
      rd_req.adr = req_addr;
      rd_req.sel = '1;
      rd_req.cti = last_beat ? `LSU_CTI_END : `LSU_CTI_INCR;
   end

   // Write beat, always single
   always_comb begin
      wr_req     = '0;
      wr_req.cyc = 1'b1;
      wr_req.stb = 1'b1;
      wr_req.we  = 1'b1;
      wr_req.adr = req_addr;
      wr_req.dat = wr_data;
      wr_req.sel = req_bsel;
      wr_req.cti = `LSU_CTI_END;
   end

   always_comb begin
      nxt_state     = state;
      nxt_req_addr  = req_addr;
      nxt_req_src   = req_src;
      nxt_req_rtype = req_rtype;
      nxt_req_burst = req_burst;
      nxt_req_bsel  = req_bsel;
      nxt_wr_data   = wr_data;
      nxt_wr_busy   = wr_busy;
      nxt_beat_cnt  = beat_cnt;
      push_valid_o  = 1'b0;
      push_flit_o   = '0;
      wb_req_o      = '0;

      case (state)
         ST_IDLE: begin
            if (in_xfer && noc_in_i.kind == FLIT_HEAD) begin
               nxt_req_src   = in_hdr.src;
               nxt_req_rtype = in_hdr.rtype;
               nxt_req_burst = in_hdr.burst;
               nxt_req_bsel  = in_hdr.bsel;
               if (in_hdr.cls != `LSU_CLASS_LSU)          nxt_state = ST_DROP;
               else if (in_hdr.msgtype == MSG_READREQ)    nxt_state = ST_RD_ADDR;
               else if (in_hdr.msgtype == MSG_WRITEREQ)   nxt_state = ST_WR_ADDR;
               else                                       nxt_state = ST_DROP;
            end else if (in_xfer && noc_in_i.kind == FLIT_MID) begin
               nxt_state = ST_DROP;  // Stray body, skip to its end
            end
         end
         ST_RD_ADDR: begin
            if (in_xfer) begin
               nxt_req_addr = noc_in_i.payload;
               nxt_beat_cnt = '0;
               nxt_state    = ST_RD_HDR;
            end
         end
         ST_RD_HDR: begin
            // FIFO was empty, head goes straight in
            push_valid_o = 1'b1;
            push_flit_o  = '{kind: FLIT_HEAD, payload: word_t'(rsp_hdr)};
            wb_req_o     = rd_req;  // First beat starts with the head
            nxt_state    = ST_RD_DATA;
         end
         ST_RD_DATA: begin
            wb_req_o = rd_req;
            if (wb_rsp_i.ack) begin
               push_valid_o = 1'b1;
               push_flit_o  = '{kind: last_beat ? FLIT_LAST : FLIT_MID,
                                payload: wb_rsp_i.dat};
               nxt_req_addr = req_addr + 32'd4;
               nxt_beat_cnt = beat_cnt + 1'b1;
               if (last_beat) nxt_state = ST_IDLE;
            end
         end
         ST_WR_ADDR: begin
            if (in_xfer) begin
               nxt_req_addr = noc_in_i.payload;
               nxt_state    = ST_WR_DATA;
            end
         end
         ST_WR_DATA: begin
            if (wr_busy) begin
               wb_req_o = wr_req;  // Hold until ack
               if (wb_rsp_i.ack) begin
                  nxt_wr_busy = 1'b0;
                  nxt_state   = ST_IDLE;
               end
            end else if (in_xfer) begin
               wb_req_o     = wr_req;
               wb_req_o.dat = noc_in_i.payload;  // Strobe in the accept cycle
               nxt_wr_data  = noc_in_i.payload;
               nxt_wr_busy  = 1'b1;
            end
         end
         ST_DROP: begin
            if (in_xfer && noc_in_i.kind == FLIT_LAST) nxt_state = ST_IDLE;
         end
         default: nxt_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_IDLE;
         wr_busy  <= 1'b0;
         beat_cnt <= '0;
      end else begin
         state    <= nxt_state;
         wr_busy  <= nxt_wr_busy;
         beat_cnt <= nxt_beat_cnt;
      end
   end

   // Request fields
   always_ff @(posedge clk) begin
      req_addr  <= nxt_req_addr;
      req_src   <= nxt_req_src;
      req_rtype <= nxt_req_rtype;
      req_burst <= nxt_req_burst;
      req_bsel  <= nxt_req_bsel;
      wr_data   <= nxt_wr_data;
   end

   a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
      wb_req_o.stb |-> wb_req_o.cyc);

   // FIFO space is checked before a read starts
   a_push_space: assert property (@(posedge clk) disable iff (rst)
      push_valid_o |-> push_ready_i);

   a_state_legal: assert property (@(posedge clk) disable iff (rst)
      state inside {ST_IDLE, ST_RD_ADDR, ST_RD_HDR, ST_RD_DATA,
                    ST_WR_ADDR, ST_WR_DATA, ST_DROP});

endmodule

// File: rtl/wb_ram.sv
// ##########################################################################
// Wishbone RAM
// Word RAM with byte select, one wait state, back-to-back burst acks
// ##########################################################################

`include "lsu_defines.svh"

module wb_ram
   import lsu_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  wb_req_t wb_req_i,
   output wb_rsp_t wb_rsp_o
);

   localparam int WORDS = 1 << `LSU_RAM_AW;

   word_t                  mem [WORDS];
   logic [`LSU_RAM_AW-1:0] word_adr;
   logic                   access;
   logic                   wait_done;  // First strobe cycle has passed

   assign word_adr     = wb_req_i.adr[`LSU_RAM_AW+1:2];  // Byte address to word
   assign access       = wb_req_i.cyc & wb_req_i.stb;
   assign wb_rsp_o.ack = access & wait_done;
   assign wb_rsp_o.dat = mem[word_adr];

   // Wait flag, kept across acks while the burst continues
   always_ff @(posedge clk) begin
      if (rst) begin
         wait_done <= 1'b0;
      end else if (!access) begin
         wait_done <= 1'b0;
      end else if (!wait_done) begin
         wait_done <= 1'b1;
      end else begin
         wait_done <= (wb_req_i.cti == `LSU_CTI_INCR);  // End of cycle clears
      end
   end

   // Byte merge under sel
   always_ff @(posedge clk) begin
      if (wb_rsp_o.ack && wb_req_i.we) begin
         for (int b = 0; b < `LSU_BSEL_W; b++) begin
            if (wb_req_i.sel[b]) mem[word_adr][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
         end
      end
   end

   // Every ack sits on a strobe that was already up a cycle earlier
   a_ack_stb: assert property (@(posedge clk) disable iff (rst)
      wb_rsp_o.ack |-> wb_req_i.stb && $past(wb_req_i.stb));

endmodule

// File: rtl/lsu_mem_top.sv
// ##########################################################################
// LSU memory node
// Endpoint, response FIFO and RAM behind one NoC port pair
// ##########################################################################

`include "lsu_defines.svh"

module lsu_mem_top
   import lsu_pkg::*;
#(
   parameter node_t NODE_ID = `LSU_NODE_ID_DEFAULT
) (
   input  logic  clk,
   input  logic  rst,
   input  flit_t noc_in_i,
   input  logic  noc_in_valid_i,
   output logic  noc_in_ready_o,
   output flit_t noc_out_o,
   output logic  noc_out_valid_o,
   input  logic  noc_out_ready_i
);

   flit_t   push_flit;
   logic    push_valid;
   logic    push_ready;
   logic    fifo_empty;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   lsu_mem_endpoint #(.NODE_ID(NODE_ID)) endpoint_i (
      .clk           (clk),
      .rst           (rst),
      .noc_in_i      (noc_in_i),
      .noc_in_valid_i(noc_in_valid_i),
      .noc_in_ready_o(noc_in_ready_o),
      .push_flit_o   (push_flit),
      .push_valid_o  (push_valid),
      .push_ready_i  (push_ready),
      .fifo_empty_i  (fifo_empty),
      .wb_req_o      (wb_req),
      .wb_rsp_i      (wb_rsp)
   );

   // Room for head plus a full line
   flit_fifo #(.DEPTH(`LSU_LINE_WORDS + 1)) rsp_fifo_i (
      .clk        (clk),
      .rst        (rst),
      .in_flit_i  (push_flit),
      .in_valid_i (push_valid),
      .in_ready_o (push_ready),
      .out_flit_o (noc_out_o),
      .out_valid_o(noc_out_valid_o),
      .out_ready_i(noc_out_ready_i),
      .empty_o    (fifo_empty)
   );

   wb_ram ram_i (
      .clk     (clk),
      .rst     (rst),
      .wb_req_i(wb_req),
      .wb_rsp_o(wb_rsp)
   );

endmodule

// File: bench/lsu_mem_tb.sv
// ##########################################################################
// LSU memory node testbench
// Request packets in, reference RAM model, response flit checks
// ##########################################################################

`include "lsu_defines.svh"

module lsu_mem_tb
   import lsu_pkg::*;
();

   localparam int          TIMEOUT = 400;  // Cycles allowed per wait
   localparam node_t       NODE_ID = `LSU_NODE_ID_DEFAULT;
   localparam logic [31:0] SEED    = 32'hd897_e137;

   logic  clk;
   logic  rst;
   flit_t noc_in_i;
   logic  noc_in_valid_i;
   logic  noc_in_ready_o;
   flit_t noc_out_o;
   logic  noc_out_valid_o;
   logic  noc_out_ready_i;

   word_t       model_mem [1 << `LSU_RAM_AW];  // Unknown until written
   flit_t       exp_q [$];                     // Expected output flits in order
   logic [31:0] stim_lfsr;
   logic [31:0] ready_lfsr;                    // Separate stream for back-pressure
   int          errors;
   int          flits_checked;
   int          tests_run;
   int          tests_bad;
   int          test_first_err;
   bit          hung;                          // Some wait ran out
   bit          ready_random;

   lsu_mem_top dut_i (
      .clk            (clk),
      .rst            (rst),
      .noc_in_i       (noc_in_i),
      .noc_in_valid_i (noc_in_valid_i),
      .noc_in_ready_o (noc_in_ready_o),
      .noc_out_o      (noc_out_o),
      .noc_out_valid_o(noc_out_valid_o),
      .noc_out_ready_i(noc_out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Fibonacci with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] next_random(input int nbits);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         stim_lfsr = lfsr_next(stim_lfsr);  // One step per bit
         r = {r[30:0], stim_lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [`LSU_RAM_AW-1:0] word_index(input word_t addr);
      return addr[`LSU_RAM_AW+1:2];  // Wraps at the RAM size
   endfunction

   function automatic void model_write(input word_t addr, input word_t data, input bsel_t bsel);
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) model_mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
      end
   endfunction

   function automatic flit_t head_flit(input logic [2:0] cls, input msgtype_e mt,
                                       input logic burst, input bsel_t bsel);
      lsu_hdr_t h;
      h         = '0;
      h.dest    = NODE_ID;
      h.cls     = cls;
      h.src     = node_t'(next_random(`LSU_NODE_W));
      h.msgtype = mt;
      h.rtype   = 1'(next_random(1));
      h.burst   = burst;
      h.bsel    = bsel;
      return '{kind: FLIT_HEAD, payload: word_t'(h)};
   endfunction

   // Reference read response built from the request header and the model words
   function automatic void expect_read_response(input lsu_hdr_t req, input word_t addr);
      lsu_hdr_t rsp;
      flit_t    f;
      int       words;
      rsp         = '0;
      rsp.dest    = req.src;
      rsp.cls     = `LSU_CLASS_LSU;
      rsp.src     = NODE_ID;
      rsp.msgtype = MSG_READRESP;
      rsp.rtype   = req.rtype;
      rsp.burst   = req.burst;
      words       = req.burst ? `LSU_LINE_WORDS : 1;
      f.kind      = FLIT_HEAD;
      f.payload   = word_t'(rsp);
      exp_q.push_back(f);
      for (int i = 0; i < words; i++) begin
         f.kind    = (i == words - 1) ? FLIT_LAST : FLIT_MID;
         f.payload = model_mem[word_index(addr + 32'(4 * i))];  // Incrementing words
         exp_q.push_back(f);
      end
   endfunction

   function automatic void report_mismatch(input string name, input logic [31:0] got,
                                           input logic [31:0] want);
      $display("Fail %s: got %h, expected %h", name, got, want);
      errors++;
   endfunction

   function automatic void check_flit(input flit_t got, input flit_t want);
      lsu_hdr_t gh;
      lsu_hdr_t wh;
      gh = lsu_hdr_t'(got.payload);
      wh = lsu_hdr_t'(want.payload);
      if (got.kind !== want.kind) begin
         report_mismatch("noc_out_o.kind", 32'(got.kind), 32'(want.kind));
      end else if (want.kind == FLIT_HEAD) begin
         if (gh.dest !== wh.dest)   report_mismatch("noc_out_o.dest", 32'(gh.dest), 32'(wh.dest));
         if (gh.src !== wh.src)     report_mismatch("noc_out_o.src", 32'(gh.src), 32'(wh.src));
         if (gh.rtype !== wh.rtype) report_mismatch("noc_out_o.rtype", 32'(gh.rtype),
                                                    32'(wh.rtype));
         if (got.payload !== want.payload) report_mismatch("noc_out_o.header", got.payload,
                                                           want.payload);
      end else if (got.payload !== want.payload) begin
         report_mismatch("noc_out_o.payload", got.payload, want.payload);
      end
   endfunction

   // Enters a step after a rising edge and leaves a step after the accepting edge
   task automatic send_flit(input flit_kind_e fkind, input word_t fdata);
      int waited;
      waited = 0;
      if (!hung) begin
         noc_in_i       = '{kind: fkind, payload: fdata};
         noc_in_valid_i = 1'b1;
         @(negedge clk);
         while (!noc_in_ready_o && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
         end
         if (!noc_in_ready_o) begin
            $display("Timeout: input flit was not accepted within %0d cycles", TIMEOUT);
            hung = 1'b1;
         end
         @(posedge clk);
         #1;
         noc_in_valid_i = 1'b0;
      end
   endtask

   task automatic send_write(input word_t addr, input word_t data, input bsel_t bsel);
      flit_t h;
      h = head_flit(`LSU_CLASS_LSU, MSG_WRITEREQ, 1'(next_random(1)), bsel);  // Size bit ignored
      model_write(addr, data, bsel);
      send_flit(h.kind, h.payload);
      send_flit(FLIT_MID, addr);
      send_flit(FLIT_LAST, data);
   endtask

   task automatic send_read(input word_t addr, input logic burst);
      flit_t h;
      h = head_flit(`LSU_CLASS_LSU, MSG_READREQ, burst, bsel_t'(next_random(4)));
      expect_read_response(lsu_hdr_t'(h.payload), addr);
      send_flit(h.kind, h.payload);
      send_flit(FLIT_LAST, addr);
   endtask

   // Until every expected flit has left the DUT
   task automatic wait_responses();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < TIMEOUT && !hung) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (exp_q.size() != 0 && !hung) begin
         $display("Timeout: %0d response flits still missing", exp_q.size());
         hung = 1'b1;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_first_err) begin
         tests_bad++;
         $display("Test %0d %s: %0d errors", tests_run, name, errors - test_first_err);
      end else begin
         $display("Test %0d %s: ok", tests_run, name);
      end
      test_first_err = errors;
   endtask

   // Back-pressure pattern
   initial begin : drive_out_ready
      ready_lfsr      = SEED;
      noc_out_ready_i = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         ready_lfsr      = lfsr_next(ready_lfsr);
         noc_out_ready_i = ready_random ? ready_lfsr[0] : 1'b1;
      end
   end

   // Compares every accepted output flit with the head of the expected queue
   initial begin : compare_outputs
      flit_t got;
      forever begin
         @(negedge clk);
         if (!rst && noc_out_valid_o && noc_out_ready_i) begin
            got = noc_out_o;
            if (exp_q.size() == 0) begin
               $display("Unexpected output flit %h while no response was pending", got);
               errors++;
            end else begin
               flits_checked++;
               check_flit(got, exp_q.pop_front());
            end
         end
      end
   end

   initial begin : run_tests
      word_t addrs [8];
      word_t base;
      flit_t h;
      rst            = 1'b1;
      noc_in_i       = '0;
      noc_in_valid_i = 1'b0;
      stim_lfsr      = SEED;
      errors         = 0;
      flits_checked  = 0;
      tests_run      = 0;
      tests_bad      = 0;
      test_first_err = 0;
      hung           = 1'b0;
      ready_random   = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      @(negedge clk);
      if (noc_out_valid_o !== 1'b0) report_mismatch("noc_out_valid_o", 32'(noc_out_valid_o), 0);
      if (noc_in_ready_o !== 1'b1)  report_mismatch("noc_in_ready_o", 32'(noc_in_ready_o), 1);
      @(posedge clk);
      #1;
      end_test("reset state");

      for (int i = 0; i < 8; i++) begin
         addrs[i] = word_t'(next_random(30) << 2);
         send_write(addrs[i], next_random(32), 4'hf);
      end
      for (int i = 0; i < 8; i++) send_read(addrs[i], 1'b0);
      wait_responses();
      end_test("single write and read");

      for (int i = 0; i < 6; i++) begin
         base = word_t'(next_random(30) << 2);
         send_write(base, next_random(32), 4'hf);    // Whole word known first
         send_write(base, next_random(32), bsel_t'(next_random(4)));
         send_read(base, 1'b0);
      end
      wait_responses();
      end_test("byte select merge");

      for (int i = 0; i < 3; i++) begin
         base = word_t'(next_random(28) << 4);        // Line aligned
         for (int j = 0; j < `LSU_LINE_WORDS; j++) begin
            send_write(base + 32'(4 * j), next_random(32), 4'hf);
         end
         send_read(base, 1'b1);
      end
      wait_responses();
      end_test("burst read");

      @(negedge clk);
      ready_random = 1'b1;
      @(posedge clk);
      #1;
      base = word_t'(next_random(28) << 4);
      for (int j = 0; j < 8; j++) send_write(base + 32'(4 * j), next_random(32), 4'hf);
      for (int i = 0; i < 8; i++) begin
         if (next_random(1) != 0) send_read(base + 32'(16 * next_random(1)), 1'b1);
         else                     send_read(base + 32'(4 * next_random(3)), 1'b0);
      end
      wait_responses();
      @(negedge clk);
      ready_random = 1'b0;
      @(posedge clk);
      #1;
      end_test("reads under back-pressure");

      h = head_flit(3'd5, MSG_READREQ, 1'b0, 4'hf);  // Foreign class with a read-like header
      send_flit(h.kind, h.payload);
      send_flit(FLIT_MID, next_random(32));
      send_flit(FLIT_MID, next_random(32));
      send_flit(FLIT_LAST, next_random(32));
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         if (noc_out_valid_o) report_mismatch("noc_out_valid_o", 32'(noc_out_valid_o), 0);
      end
      @(posedge clk);
      #1;
      send_read(addrs[0], 1'b0);
      wait_responses();
      end_test("foreign class dropped");

      $display("Totals: %0d tests, %0d with errors, %0d flits checked, %0d errors",
               tests_run, tests_bad, flits_checked, errors);
      if (errors == 0 && !hung) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/flit_fifo.sv
rtl/lsu_mem_endpoint.sv
rtl/wb_ram.sv
rtl/lsu_mem_top.sv
bench/lsu_mem_tb.sv
